// File: rtl/prcfg_ctrl_pkg.sv
// host control and status word layout for the reconfigurable DAC region
`default_nettype none

package prcfg_ctrl_pkg;

  // ********************************************************************
  // host words
  // ********************************************************************

  // control word written by the host, shared by all channels
  typedef logic [31:0] ctrl_word_t;

  // read-only status word, one per channel
  typedef logic [31:0] status_word_t;

  // ********************************************************************
  // control word fields
  // ********************************************************************

  // mode field position and width in the control word
  localparam int MODE_LSB   = 4;
  localparam int MODE_WIDTH = 4;

  // channel mode, values 3..15 freeze the DAC word
  typedef enum logic [MODE_WIDTH-1:0] {
    MODE_PASS      = 4'd0,
    MODE_PRBS_QPSK = 4'd1,
    MODE_DMA_QPSK  = 4'd2
  } mode_t;

  // ********************************************************************
  // status word fields
  // ********************************************************************

  // region identifier, sits in status bits 7:0
  localparam logic [7:0] RP_ID = 8'hA2;

  // channel number field, bits above it read as zero
  localparam int CHAN_ID_LSB   = 8;
  localparam int CHAN_ID_WIDTH = 8;

endpackage

`default_nettype wire

// File: rtl/qpsk_pkg.sv
// sample types, constellation, pulse shaping taps and PRBS rule for the QPSK path
`default_nettype none

package qpsk_pkg;

  // ********************************************************************
  // data types
  // ********************************************************************

  // one QPSK symbol, bit 0 drives I and bit 1 drives Q
  typedef logic [1:0] symbol_t;

  // signed sample on one rail
  typedef logic signed [15:0] sample_t;

  // unsigned FIR tap weight
  typedef logic [3:0] coef_t;

  // PRBS shift register state
  typedef logic [7:0] prbs_t;

  // ********************************************************************
  // constellation and pulse shape
  // ********************************************************************

  // magnitude of each rail, a symbol bit of 1 gives the negative value
  localparam sample_t QPSK_AMP = 16'sd2048;

  // tap 0 weights the newest point
  localparam int NUM_TAPS = 4;
  localparam coef_t FIR_TAPS [NUM_TAPS] = '{4'd1, 4'd3, 4'd3, 4'd1};

  // ********************************************************************
  // pseudo-random source
  // ********************************************************************

  // state after reset
  localparam prbs_t PRBS_SEED = 8'hF2;

  // next PRBS state
  // shift bits 6..0 up, refill the two low bits from the feedback taps
  function automatic prbs_t prbs_next(input prbs_t state);
    prbs_t state_next;
    state_next[7:2] = state[6:1];
    state_next[1]   = state[7] ^ state[4];
    state_next[0]   = state[6] ^ state[3];
    return state_next;
  endfunction

endpackage

`default_nettype wire

// File: rtl/pulse_shape_fir.sv
// four tap pulse shaping filter for one rail, advancing only on a strobe
`timescale 1ns/1ps
`default_nettype none

module pulse_shape_fir (
  input  wire               clk,
  input  wire               reset,

  // point stream from the mapper
  input  wire               sample_valid,
  input  wire qpsk_pkg::sample_t sample_in,

  // shaped rail
  output qpsk_pkg::sample_t sample_out
);

  // accumulator width for 16 bit samples times 4 bit weights over four taps
  localparam int ACC_WIDTH = 20;

  // stored points with entry 0 the newest
  // the oldest one drops out on the next shift
  qpsk_pkg::sample_t hist      [qpsk_pkg::NUM_TAPS-1];

  // four entry history after the shift, entry 0 is the incoming point
  qpsk_pkg::sample_t hist_next [qpsk_pkg::NUM_TAPS];

  // weighted sum of the shifted history
  logic signed [ACC_WIDTH-1:0] acc_next;

  // ********************************************************************
  // history after the shift
  // ********************************************************************

  always_comb begin
    hist_next[0] = sample_in;
    for (int k = 1; k < qpsk_pkg::NUM_TAPS; k++) begin
      hist_next[k] = hist[k-1];
    end
  end

  // ********************************************************************
  // multiply and accumulate
  // ********************************************************************

  // a zero sign bit keeps the unsigned weight positive in the signed product
  always_comb begin
    acc_next = '0;
    for (int k = 0; k < qpsk_pkg::NUM_TAPS; k++) begin
      acc_next = acc_next + hist_next[k] * $signed({1'b0, qpsk_pkg::FIR_TAPS[k]});
    end
  end

  // ********************************************************************
  // history and output registers
  // ********************************************************************

  // weights sum to 8 and the peak of 8 * 2048 still fits a sample
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int k = 0; k < qpsk_pkg::NUM_TAPS-1; k++) begin
        hist[k] <= '0;
      end
      sample_out <= '0;
    end else if (sample_valid) begin
      for (int k = 0; k < qpsk_pkg::NUM_TAPS-1; k++) begin
        hist[k] <= hist_next[k];
      end
      // output takes the sum of the new history on the same edge
      sample_out <= qpsk_pkg::sample_t'(acc_next);
    end
    // without a strobe the history and output hold
  end

endmodule

`default_nettype wire

// File: rtl/qpsk_mod.sv
// QPSK mapper that registers I/Q points and shapes each rail
`timescale 1ns/1ps
`default_nettype none

module qpsk_mod (
  input  wire                clk,
  input  wire                reset,

  // symbol stream
  input  wire                sym_valid,
  input  wire qpsk_pkg::symbol_t symbol,

  // shaped rails
  output qpsk_pkg::sample_t  qpsk_i,
  output qpsk_pkg::sample_t  qpsk_q
);

  // the two constellation levels per rail
  localparam qpsk_pkg::sample_t AMP_POS = qpsk_pkg::QPSK_AMP;
  localparam qpsk_pkg::sample_t AMP_NEG = -qpsk_pkg::QPSK_AMP;

  // mapped point, held between strobes
  qpsk_pkg::sample_t point_i;
  qpsk_pkg::sample_t point_q;

  // strobe delayed one cycle, lines up with the registered point
  logic point_valid;

  // ********************************************************************
  // symbol mapping
  // ********************************************************************

  // bit 0 picks the I sign, bit 1 the Q sign, a 1 means negative
  always_ff @(posedge clk) begin
    if (reset) begin
      point_i <= '0;
      point_q <= '0;
    end else if (sym_valid) begin
      point_i <= symbol[0] ? AMP_NEG : AMP_POS;
      point_q <= symbol[1] ? AMP_NEG : AMP_POS;
    end
  end

  // filters shift in the cycle after the point is captured
  always_ff @(posedge clk) begin
    if (reset) begin
      point_valid <= 1'b0;
    end else begin
      point_valid <= sym_valid;
    end
  end

  // ********************************************************************
  // pulse shaping, one filter per rail
  // ********************************************************************

  pulse_shape_fir i_fir_i (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (point_valid),
    .sample_in    (point_i),
    .sample_out   (qpsk_i)
  );

  pulse_shape_fir i_fir_q (
    .clk          (clk),
    .reset        (reset),
    .sample_valid (point_valid),
    .sample_in    (point_q),
    .sample_out   (qpsk_q)
  );

endmodule

`default_nettype wire

// File: rtl/prcfg_dac.sv
// one DAC channel of the region: mode select, PRBS source, QPSK modulator, output register
`timescale 1ns/1ps
`default_nettype none

module prcfg_dac #(
  parameter int CHANNEL_ID = 0,
  // at least 32, the Q:I word sits in the low 32 bits
  parameter int DATA_WIDTH = 32
) (
  input  wire                          clk,
  input  wire                          reset,

  // host control and status
  input  wire prcfg_ctrl_pkg::ctrl_word_t control,
  output prcfg_ctrl_pkg::status_word_t status,

  // FIFO side
  input  wire [DATA_WIDTH-1:0]         src_dac_data,
  output logic                         src_dac_enable,
  output logic                         src_dac_valid,

  // DAC core side
  input  wire                          dst_dac_enable,
  input  wire                          dst_dac_valid,
  output logic [DATA_WIDTH-1:0]        dst_dac_data
);

  // registered channel mode
  prcfg_ctrl_pkg::mode_t mode;

  // PRBS state
  qpsk_pkg::prbs_t prbs_state;

  // sample strobe, both DAC core levels high
  logic strobe;

  // symbol fed to the modulator
  qpsk_pkg::symbol_t mod_symbol;

  // shaped rails and the packed Q:I word
  qpsk_pkg::sample_t qpsk_i;
  qpsk_pkg::sample_t qpsk_q;
  logic [DATA_WIDTH-1:0] qpsk_word;

  // fixed status contents
  prcfg_ctrl_pkg::status_word_t status_value;

  // ********************************************************************
  // control and status
  // ********************************************************************

  // mode from the control field, used from the next edge on
  always_ff @(posedge clk) begin
    if (reset) begin
      mode <= prcfg_ctrl_pkg::MODE_PASS;
    end else begin
      mode <= prcfg_ctrl_pkg::mode_t'(
        control[prcfg_ctrl_pkg::MODE_LSB +: prcfg_ctrl_pkg::MODE_WIDTH]);
    end
  end

  // region id in the low byte, channel number above it, rest zero
  always_comb begin
    status_value = '0;
    status_value[7:0] = prcfg_ctrl_pkg::RP_ID;
    status_value[prcfg_ctrl_pkg::CHAN_ID_LSB +: prcfg_ctrl_pkg::CHAN_ID_WIDTH] =
      prcfg_ctrl_pkg::CHAN_ID_WIDTH'(CHANNEL_ID);
  end

  // status is constant, loaded on every edge
  always_ff @(posedge clk) begin
    status <= status_value;
  end

  // ********************************************************************
  // symbol source
  // ********************************************************************

  assign strobe = dst_dac_enable & dst_dac_valid;

  // sequence advances on every strobe whatever the mode
  always_ff @(posedge clk) begin
    if (reset) begin
      prbs_state <= qpsk_pkg::PRBS_SEED;
    end else if (strobe) begin
      prbs_state <= qpsk_pkg::prbs_next(prbs_state);
    end
  end

  // PRBS bits in PRBS mode, low DMA bits otherwise
  assign mod_symbol = (mode == prcfg_ctrl_pkg::MODE_PRBS_QPSK) ?
                      qpsk_pkg::symbol_t'(prbs_state[1:0]) :
                      qpsk_pkg::symbol_t'(src_dac_data[1:0]);

  // ********************************************************************
  // modulator
  // ********************************************************************

  qpsk_mod i_qpsk_mod (
    .clk       (clk),
    .reset     (reset),
    .sym_valid (strobe),
    .symbol    (mod_symbol),
    .qpsk_i    (qpsk_i),
    .qpsk_q    (qpsk_q)
  );

  // Q in the upper half, I in the lower, zero above 32 bits
  assign qpsk_word = DATA_WIDTH'({qpsk_q, qpsk_i});

  // ********************************************************************
  // output register
  // ********************************************************************

  always_ff @(posedge clk) begin
    if (reset) begin
      src_dac_enable <= 1'b0;
      src_dac_valid  <= 1'b0;
      dst_dac_data   <= '0;
    end else begin
      // FIFO side levels trail the DAC core by one cycle
      src_dac_enable <= strobe;
      src_dac_valid  <= dst_dac_valid;

      case (mode)
        prcfg_ctrl_pkg::MODE_PASS: begin
          dst_dac_data <= src_dac_data;
        end
        prcfg_ctrl_pkg::MODE_PRBS_QPSK,
        prcfg_ctrl_pkg::MODE_DMA_QPSK: begin
          dst_dac_data <= qpsk_word;
        end
        default: begin
          // unknown mode freezes the DAC word
          dst_dac_data <= dst_dac_data;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/prcfg_top.sv
// reconfigurable DAC region with one channel per DAC slice and a shared control word
`timescale 1ns/1ps
`default_nettype none

module prcfg_top #(
  parameter int NUM_CHANNELS = 2,
  parameter int DATA_WIDTH   = 32
) (
  input  wire                                   clk,
  input  wire                                   reset,

  // host side, one status word per channel
  input  wire prcfg_ctrl_pkg::ctrl_word_t          control,
  output prcfg_ctrl_pkg::status_word_t [NUM_CHANNELS-1:0] status,

  // FIFO side, one slice per channel
  input  wire [NUM_CHANNELS*DATA_WIDTH-1:0]     src_dac_data,
  output logic [NUM_CHANNELS-1:0]               src_dac_enable,
  output logic [NUM_CHANNELS-1:0]               src_dac_valid,

  // DAC core side, one slice per channel
  input  wire [NUM_CHANNELS-1:0]                dst_dac_enable,
  input  wire [NUM_CHANNELS-1:0]                dst_dac_valid,
  output logic [NUM_CHANNELS*DATA_WIDTH-1:0]    dst_dac_data
);

  // ********************************************************************
  // channels
  // ********************************************************************

  // each channel gets its slices and its index as the channel number
  for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
    prcfg_dac #(
      .CHANNEL_ID (ch),
      .DATA_WIDTH (DATA_WIDTH)
    ) i_prcfg_dac (
      .clk            (clk),
      .reset          (reset),
      .control        (control),
      .status         (status[ch]),
      .src_dac_data   (src_dac_data[ch*DATA_WIDTH +: DATA_WIDTH]),
      .src_dac_enable (src_dac_enable[ch]),
      .src_dac_valid  (src_dac_valid[ch]),
      .dst_dac_enable (dst_dac_enable[ch]),
      .dst_dac_valid  (dst_dac_valid[ch]),
      .dst_dac_data   (dst_dac_data[ch*DATA_WIDTH +: DATA_WIDTH])
    );
  end

endmodule

`default_nettype wire

// File: verif/tb_prcfg.sv
// testbench for the reconfigurable DAC region, random traffic checked against a channel model
`timescale 1ns/1ps
`default_nettype none

module tb_prcfg;

  localparam int NUM_CHANNELS = 2;
  localparam int DATA_WIDTH   = 32;

  // phase lengths in clock cycles
  localparam int RESET_CYCLES = 8;
  localparam int PASS_CYCLES  = 40;
  localparam int DMA_CYCLES   = 60;
  localparam int PRBS_CYCLES  = 60;
  localparam int HOLD_CYCLES  = 26;
  localparam int BACK_CYCLES  = 30;
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + PASS_CYCLES + DMA_CYCLES + PRBS_CYCLES +
                                  HOLD_CYCLES + BACK_CYCLES + 100;

  // DUT ports
  logic clk;
  logic reset;
  prcfg_ctrl_pkg::ctrl_word_t control;
  logic [NUM_CHANNELS*DATA_WIDTH-1:0] src_dac_data;
  logic [NUM_CHANNELS-1:0] dst_dac_enable;
  logic [NUM_CHANNELS-1:0] dst_dac_valid;
  prcfg_ctrl_pkg::status_word_t [NUM_CHANNELS-1:0] status;
  logic [NUM_CHANNELS-1:0] src_dac_enable;
  logic [NUM_CHANNELS-1:0] src_dac_valid;
  logic [NUM_CHANNELS*DATA_WIDTH-1:0] dst_dac_data;

  // channel model state
  logic [3:0]            m_mode    [NUM_CHANNELS];
  logic [7:0]            m_prbs    [NUM_CHANNELS];
  int                    m_hist_i  [NUM_CHANNELS][4];
  int                    m_hist_q  [NUM_CHANNELS][4];
  // words in flight: [0] after the mapper strobe, [1] at the FIR output
  logic [DATA_WIDTH-1:0] m_pipe    [NUM_CHANNELS][2];
  logic [DATA_WIDTH-1:0] m_out     [NUM_CHANNELS];
  logic                  m_src_en  [NUM_CHANNELS];
  logic                  m_src_val [NUM_CHANNELS];
  logic                  model_live;

  // enable and valid odds per channel, in percent
  int en_pct  [NUM_CHANNELS];
  int val_pct [NUM_CHANNELS];

  int  seed;
  int  error_count;
  int  check_count;
  int  cycle_count;
  bit  differ_seen;

  prcfg_top #(
    .NUM_CHANNELS (NUM_CHANNELS),
    .DATA_WIDTH   (DATA_WIDTH)
  ) DUT (
    .clk            (clk),
    .reset          (reset),
    .control        (control),
    .status         (status),
    .src_dac_data   (src_dac_data),
    .src_dac_enable (src_dac_enable),
    .src_dac_valid  (src_dac_valid),
    .dst_dac_enable (dst_dac_enable),
    .dst_dac_valid  (dst_dac_valid),
    .dst_dac_data   (dst_dac_data)
  );

  // 40 ns clock
  always #20 clk = ~clk;

  // **********************************************************************
  // model helpers
  // **********************************************************************

  // shift up by one, feedback refills bits 1 and 0
  function automatic logic [7:0] prbs_step(input logic [7:0] s);
    logic [7:0] n;
    n    = {s[6:0], 1'b0};
    n[1] = s[7] ^ s[4];
    n[0] = s[6] ^ s[3];
    return n;
  endfunction

  // symbol bit 0 gives plus amplitude, 1 gives minus
  function automatic int rail_level(input logic b);
    return b ? -int'(qpsk_pkg::QPSK_AMP) : int'(qpsk_pkg::QPSK_AMP);
  endfunction

  // weighted sum of one rail history, newest point on tap 0
  function automatic int tap_sum(input int h0, input int h1, input int h2, input int h3);
    return h0 * int'(qpsk_pkg::FIR_TAPS[0]) + h1 * int'(qpsk_pkg::FIR_TAPS[1]) +
           h2 * int'(qpsk_pkg::FIR_TAPS[2]) + h3 * int'(qpsk_pkg::FIR_TAPS[3]);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED %s: actual %h expected %h at %0t", name, actual, expected, $time);
    end
  endtask

  // **********************************************************************
  // stimulus
  // **********************************************************************

  // random traffic for a number of cycles, mode field steps through mode..mode+span-1
  task automatic run_phase(input logic [3:0] mode, input int cycles, input int span);
    logic [31:0] ctrl;
    for (int k = 0; k < cycles; k++) begin
      @(posedge clk);
      // bits outside the mode field are noise
      ctrl = $random(seed);
      ctrl[prcfg_ctrl_pkg::MODE_LSB +: 4] = 4'(int'(mode) + (k % span));
      control <= ctrl;
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        src_dac_data[ch*DATA_WIDTH +: DATA_WIDTH] <= $random(seed);
        dst_dac_enable[ch] <= ($unsigned($random(seed)) % 100) < en_pct[ch];
        dst_dac_valid[ch]  <= ($unsigned($random(seed)) % 100) < val_pct[ch];
      end
    end
  endtask

  // **********************************************************************
  // reference model, steps on the same edge as the DUT
  // **********************************************************************

  always @(posedge clk) begin : model_step
    logic strobe;
    logic [1:0] sym;
    logic [DATA_WIDTH-1:0] din;
    int acc_i;
    int acc_q;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      din    = src_dac_data[ch*DATA_WIDTH +: DATA_WIDTH];
      strobe = dst_dac_enable[ch] & dst_dac_valid[ch];
      if (reset) begin
        m_mode[ch]    = prcfg_ctrl_pkg::MODE_PASS;
        m_prbs[ch]    = qpsk_pkg::PRBS_SEED;
        m_pipe[ch][0] = '0;
        m_pipe[ch][1] = '0;
        m_out[ch]     = '0;
        m_src_en[ch]  = 1'b0;
        m_src_val[ch] = 1'b0;
        for (int k = 0; k < 4; k++) begin
          m_hist_i[ch][k] = 0;
          m_hist_q[ch][k] = 0;
        end
      end else begin
        // output register follows the mode registered one edge earlier
        case (m_mode[ch])
          prcfg_ctrl_pkg::MODE_PASS:      m_out[ch] = din;
          prcfg_ctrl_pkg::MODE_PRBS_QPSK: m_out[ch] = m_pipe[ch][1];
          prcfg_ctrl_pkg::MODE_DMA_QPSK:  m_out[ch] = m_pipe[ch][1];
          default:                        m_out[ch] = m_out[ch];
        endcase
        m_pipe[ch][1] = m_pipe[ch][0];
        if (strobe) begin
          sym = (m_mode[ch] == prcfg_ctrl_pkg::MODE_PRBS_QPSK) ? m_prbs[ch][1:0] : din[1:0];
          for (int k = 3; k > 0; k--) begin
            m_hist_i[ch][k] = m_hist_i[ch][k-1];
            m_hist_q[ch][k] = m_hist_q[ch][k-1];
          end
          m_hist_i[ch][0] = rail_level(sym[0]);
          m_hist_q[ch][0] = rail_level(sym[1]);
          acc_i = tap_sum(m_hist_i[ch][0], m_hist_i[ch][1], m_hist_i[ch][2], m_hist_i[ch][3]);
          acc_q = tap_sum(m_hist_q[ch][0], m_hist_q[ch][1], m_hist_q[ch][2], m_hist_q[ch][3]);
          // Q in the upper half, I in the lower
          m_pipe[ch][0] = DATA_WIDTH'({acc_q[15:0], acc_i[15:0]});
          // PRBS moves on every strobe, in any mode
          m_prbs[ch] = prbs_step(m_prbs[ch]);
        end
        m_src_en[ch]  = strobe;
        m_src_val[ch] = dst_dac_valid[ch];
        m_mode[ch]    = control[prcfg_ctrl_pkg::MODE_LSB +: 4];
      end
    end
    model_live = 1'b1;
  end

  // **********************************************************************
  // output checks, mid cycle when everything is settled
  // **********************************************************************

  always @(negedge clk) begin
    if (model_live) begin
      for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
        // region id low, channel number in 15:8
        check_value($sformatf("status[%0d]", ch), status[ch],
                    {16'h0, 8'(ch), prcfg_ctrl_pkg::RP_ID});
        check_value($sformatf("src_dac_enable[%0d]", ch), 32'(src_dac_enable[ch]),
                    32'(m_src_en[ch]));
        check_value($sformatf("src_dac_valid[%0d]", ch), 32'(src_dac_valid[ch]),
                    32'(m_src_val[ch]));
        check_value($sformatf("dst_dac_data[%0d]", ch),
                    dst_dac_data[ch*DATA_WIDTH +: DATA_WIDTH], m_out[ch]);
      end
      // both channels in PRBS mode but with their own strobe patterns
      if (m_mode[0] == prcfg_ctrl_pkg::MODE_PRBS_QPSK &&
          dst_dac_data[DATA_WIDTH-1:0] !== dst_dac_data[2*DATA_WIDTH-1:DATA_WIDTH]) begin
        differ_seen = 1'b1;
      end
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // **********************************************************************
  // test sequence
  // **********************************************************************

  initial begin
    seed           = 32'h77a0_3591;
    clk            = 1'b0;
    reset          = 1'b1;
    control        = '0;
    src_dac_data   = '0;
    dst_dac_enable = '0;
    dst_dac_valid  = '0;
    error_count    = 0;
    check_count    = 0;
    cycle_count    = 0;
    model_live     = 1'b0;
    differ_seen    = 1'b0;
    // about 60 percent strobes on each channel, different mixes
    en_pct[0]  = 80;
    val_pct[0] = 75;
    en_pct[1]  = 70;
    val_pct[1] = 85;

    // traffic under reset must not reach the outputs
    run_phase(prcfg_ctrl_pkg::MODE_PASS, RESET_CYCLES, 1);
    reset <= 1'b0;

    run_phase(prcfg_ctrl_pkg::MODE_PASS, PASS_CYCLES, 1);
    run_phase(prcfg_ctrl_pkg::MODE_DMA_QPSK, DMA_CYCLES, 1);
    run_phase(prcfg_ctrl_pkg::MODE_PRBS_QPSK, PRBS_CYCLES, 1);
    // walk the mode field through 3..15, output must stay frozen
    run_phase(4'd3, HOLD_CYCLES, 13);
    run_phase(prcfg_ctrl_pkg::MODE_DMA_QPSK, BACK_CYCLES, 1);

    // drain the pipeline and let the last checks run
    repeat (3) @(posedge clk);
    @(negedge clk);
    #1;

    if (!differ_seen) begin
      error_count++;
      $display("error: the two channels never gave different words in PRBS mode");
    end

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
rtl/prcfg_ctrl_pkg.sv
rtl/qpsk_pkg.sv
rtl/pulse_shape_fir.sv
rtl/qpsk_mod.sv
rtl/prcfg_dac.sv
rtl/prcfg_top.sv
verif/tb_prcfg.sv
